/* all.f */
rtl/exec_pkg.sv
rtl/exec_if.sv
rtl/int_alu.sv
rtl/branch_cmp.sv
rtl/exec_result.sv
rtl/exec_stage.sv
testbench/exec_stage_chk.sv
testbench/exec_stage_tb.sv

/* rtl/branch_cmp.sv */
`timescale 1ns/1ns

module branch_cmp (
    exec_if.cmp  bus,
    output logic taken
);
    import exec_pkg::*;

    logic eq;
    logic lt;
    logic ltu;
    logic [br_do-1:0] cond; // one bit per mask position below br_do
    logic [br_do-1:0] hit;

    assign eq  = bus.op1 == bus.op2;
    assign lt  = $signed(bus.op1) < $signed(bus.op2);
    assign ltu = bus.op1 < bus.op2;

    always_comb begin
        cond         = '0;
        cond[br_eq]  = eq;
        cond[br_ne]  = ~eq;
        cond[br_lt]  = lt;
        cond[br_ge]  = ~lt;  // signed >=
        cond[br_ltu] = ltu;
        cond[br_geu] = ~ltu;
    end

    // any requested condition that holds
    assign hit = cond & bus.dec_branch[br_do-1:0];

    // nothing is taken without br_do
    assign taken = bus.dec_branch[br_do] & (|hit);

endmodule

/* rtl/exec_if.sv */
`timescale 1ns/1ns

// operand bundle shared by the integer unit and the comparator
interface exec_if;
    import exec_pkg::*;

    word_t   op1;
    word_t   op2;
    op_t     aluctl;     // operation code incl. variant bit
    brmask_t dec_branch; // branch conditions from decode

    // driven from the top level inputs
    modport source (output op1, output op2, output aluctl, output dec_branch);

    modport alu (input op1, input op2, input aluctl);

    // comparator ignores the operation code
    modport cmp (input op1, input op2, input dec_branch);

endinterface

/* rtl/exec_pkg.sv */
package exec_pkg;

    // datapath width
    localparam int xlen = 32;
    localparam int op_w = 7;       // full operation code
    localparam int op_field_w = 6; // operation part, bits 5..0
    localparam int br_w = 7;       // branch mask width

    // bit 6 of the code picks sub / sra
    localparam int op_var_bit = 6;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [op_w-1:0]       op_t;
    typedef logic [op_field_w-1:0] op_field_t;
    typedef logic [br_w-1:0]       brmask_t;

    // register group, codes 0..7
    localparam op_field_t op_add  = 6'd0; // sub with variant bit
    localparam op_field_t op_sll  = 6'd1;
    localparam op_field_t op_srl  = 6'd2; // sra with variant bit
    localparam op_field_t op_slt  = 6'd3;
    localparam op_field_t op_sltu = 6'd4;
    localparam op_field_t op_xor  = 6'd5;
    localparam op_field_t op_or   = 6'd6;
    localparam op_field_t op_and  = 6'd7;

    // immediate group repeats the register group from here
    localparam op_field_t op_imm_base = 6'd32;

    // upper immediate merge
    localparam op_field_t op_lui = 6'd42;

    // stores pass op2 through as data
    localparam op_field_t op_sw  = 6'd54;
    localparam op_field_t op_fsw = 6'd55;

    // branch mask bit positions, as set by the decoder
    localparam int br_eq  = 0;
    localparam int br_ne  = 1;
    localparam int br_lt  = 2;
    localparam int br_ge  = 3;
    localparam int br_ltu = 4;
    localparam int br_geu = 5;
    localparam int br_do  = 6; // qualifies all of the above

endpackage

/* rtl/exec_result.sv */
`timescale 1ns/1ns

module exec_result (
    input  logic            clk,
    input  logic            rst,
    input  logic            advance, // low means stall
    input  exec_pkg::word_t alu_res,
    input  logic            taken,
    output exec_pkg::word_t wb_res,
    output exec_pkg::word_t alu_fwd,
    output logic            npc_en,
    output logic            flush
);

    // write-back register, frozen while stalled
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_res <= '0;
        end else if (advance) begin
            wb_res <= alu_res;
        end
    end

    // bypass path, same cycle as the operands
    assign alu_fwd = alu_res;

    // a taken branch redirects fetch and kills younger stages
    assign npc_en = taken;
    assign flush  = taken;

endmodule

/* rtl/exec_stage.sv */
`timescale 1ns/1ns

module exec_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              advance,
    input  exec_pkg::word_t   op1,
    input  exec_pkg::word_t   op2,
    input  exec_pkg::op_t     aluctl,
    input  exec_pkg::brmask_t dec_branch,
    output exec_pkg::word_t   wb_res,
    output exec_pkg::word_t   alu_fwd,
    output logic              npc_en,
    output logic              flush
);
    import exec_pkg::*;

    word_t alu_res; // integer unit to result stage
    logic  taken;   // comparator to result stage

    exec_if ops_if ();

    // top level ports feed the operand bundle
    assign ops_if.op1        = op1;
    assign ops_if.op2        = op2;
    assign ops_if.aluctl     = aluctl;
    assign ops_if.dec_branch = dec_branch;

    int_alu int_alu_inst (
        .bus     (ops_if.alu),
        .alu_res (alu_res)
    );

    branch_cmp branch_cmp_inst (
        .bus   (ops_if.cmp),
        .taken (taken)
    );

    exec_result exec_result_inst (
        .clk     (clk),
        .rst     (rst),
        .advance (advance),
        .alu_res (alu_res),
        .taken   (taken),
        .wb_res  (wb_res),
        .alu_fwd (alu_fwd),
        .npc_en  (npc_en),
        .flush   (flush)
    );

endmodule

/* rtl/int_alu.sv */
`timescale 1ns/1ns

module int_alu (
    exec_if.alu             bus,
    output exec_pkg::word_t alu_res
);
    import exec_pkg::*;

    logic [4:0] shamt; // only low five bits of op2 count
    logic       var_sel;
    op_field_t  op_sel;

    word_t add_res;
    word_t sub_res;
    word_t sll_res;
    word_t srl_res;
    word_t sra_res;
    word_t slt_res;
    word_t sltu_res;
    word_t xor_res;
    word_t or_res;
    word_t and_res;
    word_t lui_res;

    assign shamt   = bus.op2[4:0];
    assign var_sel = bus.aluctl[op_var_bit];
    assign op_sel  = bus.aluctl[op_field_w-1:0];

    // every candidate is formed in parallel, the case below just picks
    assign add_res = bus.op1 + bus.op2;
    assign sub_res = bus.op1 - bus.op2;

    assign sll_res = bus.op1 << shamt;
    assign srl_res = bus.op1 >> shamt;
    assign sra_res = word_t'($signed(bus.op1) >>> shamt); // sign fill

    // two's complement compare
    assign slt_res  = {{(xlen-1){1'b0}}, $signed(bus.op1) < $signed(bus.op2)};
    assign sltu_res = {{(xlen-1){1'b0}}, bus.op1 < bus.op2};

    assign xor_res = bus.op1 ^ bus.op2;
    assign or_res  = bus.op1 | bus.op2;
    assign and_res = bus.op1 & bus.op2;

    // op2 low half goes on top
    assign lui_res = {bus.op2[15:0], bus.op1[15:0]};

    always_comb begin
        unique case (op_sel)
            // register group
            op_add:  alu_res = var_sel ? sub_res : add_res;
            op_sll:  alu_res = sll_res;
            op_srl:  alu_res = var_sel ? sra_res : srl_res;
            op_slt:  alu_res = slt_res;
            op_sltu: alu_res = sltu_res;
            op_xor:  alu_res = xor_res;
            op_or:   alu_res = or_res;
            op_and:  alu_res = and_res;

            // immediate group, no sub here
            op_imm_base + op_add:  alu_res = add_res;
            op_imm_base + op_sll:  alu_res = sll_res;
            op_imm_base + op_srl:  alu_res = var_sel ? sra_res : srl_res;
            op_imm_base + op_slt:  alu_res = slt_res;
            op_imm_base + op_sltu: alu_res = sltu_res;
            op_imm_base + op_xor:  alu_res = xor_res;
            op_imm_base + op_or:   alu_res = or_res;
            op_imm_base + op_and:  alu_res = and_res;

            op_lui: alu_res = lui_res;

            // store data
            op_sw:  alu_res = bus.op2;
            op_fsw: alu_res = bus.op2;

            // mul/div, float, load, branch, jump and unassigned codes
            default: alu_res = '0;
        endcase
    end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert \
    -f all.f \
    --top-module exec_stage_tb \
    --Mdir obj_dir \
    -o exec_stage_sim
status=$?
if [ $status -ne 0 ]; then
    echo "run.sh: Verilator build failed with status $status"
    exit 1
fi

./obj_dir/exec_stage_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "run.sh: simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench failed" "$log"; then
    echo "run.sh: FAIL"
    exit 1
fi

echo "run.sh: PASS"
exit 0

/* testbench/exec_stage_chk.sv */
`timescale 1ns/1ns

module exec_stage_chk (
    input logic              clk,
    input logic              rst,
    input logic              advance,
    input exec_pkg::brmask_t dec_branch,
    input exec_pkg::word_t   wb_res,
    input logic              npc_en,
    input logic              flush
);
    import exec_pkg::*;

    // register cleared one edge after reset is seen
    wb_res_cleared: assert property (@(posedge clk) rst |=> wb_res == '0)
        else $error("wb_res not zero after reset");

    // a stall freezes the write-back value
    wb_res_held: assert property (@(posedge clk) (!rst && !advance) |=> $stable(wb_res))
        else $error("wb_res changed while advance was low");

    // no redirect or flush unless decode set br_do
    flush_needs_br_do: assert property (@(posedge clk)
        !dec_branch[br_do] |-> (!npc_en && !flush))
        else $error("npc_en or flush high with br_do clear");

endmodule

bind exec_stage exec_stage_chk exec_stage_chk_inst (
    .clk        (clk),
    .rst        (rst),
    .advance    (advance),
    .dec_branch (dec_branch),
    .wb_res     (wb_res),
    .npc_en     (npc_en),
    .flush      (flush)
);

/* testbench/exec_stage_tb.sv */
`timescale 1ns/1ns

module exec_stage_tb;
    import exec_pkg::*;

    // about 210 cycles of tests, limit at roughly twice that
    localparam int max_cycles = 400;

    logic    clk = 1'b0;
    logic    rst;
    logic    advance;
    word_t   op1;
    word_t   op2;
    op_t     aluctl;
    brmask_t dec_branch;
    word_t   wb_res;
    word_t   alu_fwd;
    logic    npc_en;
    logic    flush;

    word_t exp_wb;          // what wb_res should hold now
    int    word_errors = 0;
    int    flag_errors = 0;
    int    cycle_count = 0;
    int    seed = 21;

    exec_stage exec_stage_inst (
        .clk        (clk),
        .rst        (rst),
        .advance    (advance),
        .op1        (op1),
        .op2        (op2),
        .aluctl     (aluctl),
        .dec_branch (dec_branch),
        .wb_res     (wb_res),
        .alu_fwd    (alu_fwd),
        .npc_en     (npc_en),
        .flush      (flush)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("timeout: tests did not finish within %0d cycles", max_cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    // integer result from the opcode rules
    function automatic word_t model_alu(input op_t op, input word_t a, input word_t b);
        logic [4:0] sh;
        logic       alt;
        word_t      res;
        sh  = b[4:0];   // only five bits of shift amount
        alt = op[6];
        if (op[5:3] == 3'b000 || op[5:3] == 3'b100) begin
            case (op[2:0])
                3'd0: res = (alt && !op[5]) ? a - b : a + b; // immediate add never subtracts
                3'd1: res = a << sh;
                3'd2: res = alt ? ((a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0))
                                : a >> sh;
                3'd3: res = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
                3'd4: res = (a < b) ? 32'd1 : 32'd0;
                3'd5: res = a ^ b;
                3'd6: res = a | b;
                3'd7: res = a & b;
            endcase
        end else if (op[5:0] == 6'd42) begin
            res = {b[15:0], a[15:0]};
        end else if (op[5:0] == 6'd54 || op[5:0] == 6'd55) begin
            res = b;
        end else begin
            res = '0;
        end
        return res;
    endfunction

    function automatic logic model_taken(input brmask_t m, input word_t a, input word_t b);
        logic eq;
        logic lt_s;
        logic lt_u;
        logic hit;
        eq   = (a == b);
        lt_u = (a < b);
        lt_s = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)); // flip sign, compare unsigned
        hit  = (m[br_eq] && eq) || (m[br_ne] && !eq)
            || (m[br_lt] && lt_s) || (m[br_ge] && !lt_s)
            || (m[br_ltu] && lt_u) || (m[br_geu] && !lt_u);
        return m[br_do] && hit;
    endfunction

    task automatic check_word(input string what, input word_t got, input word_t expected);
        if (got !== expected) begin
            word_errors++;
            $display("FAILED at %0t: %s is %h, expected %h (aluctl %h)",
                     $time, what, got, expected, aluctl);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic expected);
        if (got !== expected) begin
            flag_errors++;
            $display("FAILED at %0t: %s is %b, expected %b (mask %b, op1 %h, op2 %h)",
                     $time, what, got, expected, dec_branch, op1, op2);
        end
    endtask

    // one cycle, starts and ends on a falling edge
    task automatic apply_and_check(input op_t op, input word_t a, input word_t b,
                                   input brmask_t m, input logic adv);
        word_t exp_res;
        logic  exp_taken;
        exp_res    = model_alu(op, a, b);
        exp_taken  = model_taken(m, a, b);
        op1        = a;
        op2        = b;
        aluctl     = op;
        dec_branch = m;
        advance    = adv;
        @(posedge clk);
        check_word("alu_fwd", alu_fwd, exp_res);  // inputs settled half a cycle ago
        check_flag("npc_en", npc_en, exp_taken);
        check_flag("flush", flush, exp_taken);
        if (adv) begin
            exp_wb = exp_res;
        end
        @(negedge clk);
        check_word("wb_res", wb_res, exp_wb);
    endtask

    task automatic test_reset();
        rst = 1'b0;
        @(posedge clk);
        check_flag("npc_en", npc_en, 1'b0);
        check_flag("flush", flush, 1'b0);
        @(negedge clk);
        check_word("wb_res", wb_res, '0);
    endtask

    task automatic test_register_group();
        for (int code = 0; code < 8; code++) begin
            for (int v = 0; v < 2; v++) begin
                for (int n = 0; n < 6; n++) begin
                    apply_and_check(op_t'({v[0], 6'(code)}), $random(seed), $random(seed),
                                    '0, 1'b1);
                end
            end
        end
        // shift amounts past 31 wrap to the low five bits
        apply_and_check(op_t'(op_sll), 32'h8765_4321, 32'd37, '0, 1'b1);
        apply_and_check(op_t'(op_srl), 32'h8765_4321, 32'hffff_ffe1, '0, 1'b1);
        apply_and_check(op_t'({1'b1, op_srl}), 32'h8765_4321, 32'd40, '0, 1'b1);
        apply_and_check(op_t'({1'b1, op_srl}), 32'h8000_0000, 32'd63, '0, 1'b1);
    endtask

    task automatic test_immediate_group();
        for (int code = 32; code < 40; code++) begin
            for (int v = 0; v < 2; v++) begin
                apply_and_check(op_t'({v[0], 6'(code)}), $random(seed), $random(seed),
                                '0, 1'b1);
            end
        end
        for (int v = 0; v < 2; v++) begin
            apply_and_check(op_t'({v[0], op_lui}), $random(seed), $random(seed), '0, 1'b1);
            apply_and_check(op_t'({v[0], op_sw}), $random(seed), $random(seed), '0, 1'b1);
            apply_and_check(op_t'({v[0], op_fsw}), $random(seed), $random(seed), '0, 1'b1);
        end
    endtask

    task automatic test_stall();
        apply_and_check(op_t'(op_xor), $random(seed), $random(seed), '0, 1'b1);
        // operands keep moving, wb_res must not
        repeat (5) begin
            apply_and_check(op_t'(op_add), $random(seed), $random(seed), '0, 1'b0);
        end
        apply_and_check(op_t'(op_or), $random(seed), $random(seed), '0, 1'b1);
    endtask

    task automatic test_branches();
        word_t   pair_a[4];
        word_t   pair_b[4];
        brmask_t m;
        pair_a[0] = 32'h1234_5678;
        pair_b[0] = 32'h1234_5678;
        pair_a[1] = 32'hffff_fff0; // negative vs positive
        pair_b[1] = 32'h0000_0010;
        pair_a[2] = 32'h0000_0010;
        pair_b[2] = 32'hffff_fff0;
        pair_a[3] = $random(seed);
        pair_b[3] = $random(seed);
        for (int bit_pos = 0; bit_pos < br_do; bit_pos++) begin
            for (int p = 0; p < 4; p++) begin
                for (int d = 0; d < 2; d++) begin
                    m          = '0;
                    m[bit_pos] = 1'b1;
                    m[br_do]   = (d == 1);
                    apply_and_check(op_t'(op_add), pair_a[p], pair_b[p], m, 1'b1);
                end
            end
        end
    endtask

    task automatic test_excluded_codes();
        // mul/div and float slots plus unused holes
        int excluded[14] = '{8, 11, 12, 15, 16, 23, 24, 31, 40, 41, 43, 48, 53, 63};
        foreach (excluded[i]) begin
            for (int v = 0; v < 2; v++) begin
                apply_and_check(op_t'({v[0], 6'(excluded[i])}), $random(seed), $random(seed),
                                '0, 1'b1);
            end
        end
    endtask

    initial begin
        rst        = 1'b1;
        advance    = 1'b0;
        op1        = '0;
        op2        = '0;
        aluctl     = '0;
        dec_branch = '0;
        exp_wb     = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);

        test_reset();
        test_register_group();
        test_immediate_group();
        test_stall();
        test_branches();
        test_excluded_codes();

        $display("errors: %0d total, %0d word, %0d flag",
                 word_errors + flag_errors, word_errors, flag_errors);
        if (word_errors + flag_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
